/* logic/tx_mf_pkg.sv */
package tx_mf_pkg;

	// datapath widths
	localparam int sample_w = 18;
	// pair sums need one extra bit over a sample
	localparam int pair_w = 19;
	localparam int prod_w = 18;
	// 11 products of prod_w bits cannot overflow acc_w
	localparam int acc_w = 22;

	// filter geometry
	localparam int num_taps = 21;
	localparam int num_pairs = 11;

	// one PAM step, full scale is 3 steps = 65535
	localparam int level_unit = 21845;

	// sample levels for symbol codes 0..3
	localparam logic signed [sample_w-1:0] sym_level [4] = '{
		-18'sd65535,
		-18'sd21845,
		18'sd21845,
		18'sd65535
	};

	// half-width of the window around each pair-sum level
	localparam int level_tol = 2631;

	// product for a pair sum of +2 level units, i.e. one step per sample
	// entry 10 is halved since the center sample arrives doubled
	localparam logic signed [prod_w-1:0] tap_coef [num_pairs] = '{
		18'sd398,
		18'sd817,
		18'sd553,
		-18'sd1047,
		-18'sd3477,
		-18'sd4566,
		-18'sd1442,
		18'sd7268,
		18'sd19619,
		18'sd30651,
		18'sd17541
	};

	// host register map
	typedef enum logic [1:0] {
		reg_symbol = 2'd0,
		reg_sample = 2'd1,
		reg_output = 2'd2,
		reg_unused = 2'd3
	} reg_addr_e;

endpackage

/* logic/tx_mf_tap.sv */
`timescale 1ns/1ps

module tx_mf_tap (
	input  logic signed [tx_mf_pkg::pair_w-1:0] pair_sum,
	input  logic signed [tx_mf_pkg::prod_w-1:0] coef,
	output logic signed [tx_mf_pkg::prod_w-1:0] product
);
	import tx_mf_pkg::*;

	// two guard bits hold 3 x coef before the final slice
	localparam int wide_w = prod_w + 2;

	int ps_ext;
	logic neg;
	logic [1:0] mag;
	logic signed [wide_w-1:0] coef_x1;
	logic signed [wide_w-1:0] coef_x2;
	logic signed [wide_w-1:0] coef_x3;
	logic signed [wide_w-1:0] sel;
	logic signed [wide_w-1:0] signed_sel;

	assign ps_ext = int'(pair_sum);

	// level m sits at m * 2 * level_unit, windows never overlap
	// off-level inputs leave mag at zero and contribute nothing
	always_comb begin
		neg = 1'b0;
		mag = 2'd0;
		for (int m = -3; m <= 3; m++) begin
			if ((ps_ext > (2 * m * level_unit) - level_tol) &&
				(ps_ext < (2 * m * level_unit) + level_tol)) begin
				neg = (m < 0);
				mag = (m < 0) ? 2'(-m) : 2'(m);
			end
		end
	end

	// multiples of the coefficient from shifts and one add
	assign coef_x1 = {{2{coef[prod_w-1]}}, coef};
	assign coef_x2 = coef_x1 <<< 1;
	assign coef_x3 = coef_x2 + coef_x1;

	always_comb begin
		case (mag)
			2'd1: begin
				sel = coef_x1;
			end
			2'd2: begin
				sel = coef_x2;
			end
			2'd3: begin
				sel = coef_x3;
			end
			default: begin
				sel = '0;
			end
		endcase
	end

	assign signed_sel = neg ? -sel : sel;

	assign product = signed_sel[prod_w-1:0];

endmodule

/* logic/tx_mf_delay_line.sv */
`timescale 1ns/1ps

module tx_mf_delay_line (
	input  logic clk,
	input  logic reset,
	input  logic push,
	input  logic signed [tx_mf_pkg::sample_w-1:0] push_sample,
	output logic signed [tx_mf_pkg::pair_w-1:0] pair_sum [tx_mf_pkg::num_pairs]
);
	import tx_mf_pkg::*;

	// sample history, position 0 is the newest
	logic signed [sample_w-1:0] hist [num_taps];

	// one shift per push, no free-running stream
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < num_taps; i++) begin
				hist[i] <= '0;
			end
		end else if (push) begin
			hist[0] <= push_sample;
			for (int i = 1; i < num_taps; i++) begin
				hist[i] <= hist[i-1];
			end
		end
	end

	// fold the symmetric taps, k pairs with 20-k
	always_comb begin
		for (int k = 0; k < num_pairs - 1; k++) begin
			pair_sum[k] = {hist[k][sample_w-1], hist[k]}
				+ {hist[num_taps-1-k][sample_w-1], hist[num_taps-1-k]};
		end
		// center has no partner, doubling keeps it on the pair-sum levels
		pair_sum[num_pairs-1] = {hist[num_pairs-1], 1'b0};
	end

endmodule

/* logic/tx_mf_adder_tree.sv */
`timescale 1ns/1ps

module tx_mf_adder_tree (
	input  logic clk,
	input  logic reset,
	input  logic signed [tx_mf_pkg::prod_w-1:0] product [tx_mf_pkg::num_pairs],
	output logic signed [tx_mf_pkg::acc_w-1:0] filt_out
);
	import tx_mf_pkg::*;

	logic signed [acc_w-1:0] prod_ext [num_pairs];
	logic signed [acc_w-1:0] sum_l1 [6];
	logic signed [acc_w-1:0] sum_l2 [3];
	logic signed [acc_w-1:0] total;

	// widen first so no stage of the tree can overflow
	always_comb begin
		for (int i = 0; i < num_pairs; i++) begin
			prod_ext[i] = {{(acc_w - prod_w){product[i][prod_w-1]}}, product[i]};
		end
	end

	// 11 -> 6, the center product passes straight through
	always_comb begin
		for (int i = 0; i < 5; i++) begin
			sum_l1[i] = prod_ext[2*i] + prod_ext[2*i+1];
		end
		sum_l1[5] = prod_ext[num_pairs-1];
	end

	// 6 -> 3
	always_comb begin
		for (int i = 0; i < 3; i++) begin
			sum_l2[i] = sum_l1[2*i] + sum_l1[2*i+1];
		end
	end

	// 3 -> 1
	assign total = sum_l2[0] + sum_l2[1] + sum_l2[2];

	always_ff @(posedge clk) begin
		if (reset) begin
			filt_out <= '0;
		end else begin
			filt_out <= total;
		end
	end

endmodule

/* logic/tx_mf_wb_regs.sv */
`timescale 1ns/1ps

module tx_mf_wb_regs (
	input  logic clk,
	input  logic reset,
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  logic [1:0] wb_adr,
	input  logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic wb_ack,
	input  logic signed [tx_mf_pkg::acc_w-1:0] filt_out,
	output logic push,
	output logic signed [tx_mf_pkg::sample_w-1:0] push_sample
);
	import tx_mf_pkg::*;

	logic req;
	logic wr_req;
	logic rd_req;
	logic push_addr;
	reg_addr_e addr;

	// a request is new until the ack for it has been seen
	assign req = wb_cyc && wb_stb && !wb_ack;
	assign wr_req = req && wb_we;
	assign rd_req = req && !wb_we;

	assign addr = reg_addr_e'(wb_adr);

	// only the two sample registers feed the delay line
	assign push_addr = (addr == reg_symbol) || (addr == reg_sample);

	// ack and push rise together, one cycle after the request
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_ack <= 1'b0;
			push <= 1'b0;
		end else begin
			wb_ack <= req;
			push <= wr_req && push_addr;
		end
	end

	// sample that enters the line with the push pulse
	always_ff @(posedge clk) begin
		if (wr_req) begin
			case (addr)
				reg_symbol: begin
					push_sample <= sym_level[wb_dat_w[1:0]];
				end
				reg_sample: begin
					push_sample <= $signed(wb_dat_w[sample_w-1:0]);
				end
				default: begin
					push_sample <= push_sample;
				end
			endcase
		end
	end

	// read data is presented together with the ack
	always_ff @(posedge clk) begin
		if (rd_req) begin
			case (addr)
				reg_output: begin
					wb_dat_r <= {{(32 - acc_w){filt_out[acc_w-1]}}, filt_out};
				end
				default: begin
					// write-only and unused registers read as zero
					wb_dat_r <= '0;
				end
			endcase
		end
	end

endmodule

/* logic/tx_mf_top.sv */
`timescale 1ns/1ps

module tx_mf_top (
	input  logic clk,
	input  logic reset,
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  logic [1:0] wb_adr,
	input  logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic wb_ack
);
	import tx_mf_pkg::*;

	logic push;
	logic signed [sample_w-1:0] push_sample;
	logic signed [pair_w-1:0] pair_sum [num_pairs];
	logic signed [prod_w-1:0] product [num_pairs];
	logic signed [acc_w-1:0] filt_out;

	// host side, sample pushes and readback
	tx_mf_wb_regs i_wb_regs (
		.clk         (clk),
		.reset       (reset),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w),
		.wb_dat_r    (wb_dat_r),
		.wb_ack      (wb_ack),
		.filt_out    (filt_out),
		.push        (push),
		.push_sample (push_sample)
	);

	tx_mf_delay_line i_delay_line (
		.clk         (clk),
		.reset       (reset),
		.push        (push),
		.push_sample (push_sample),
		.pair_sum    (pair_sum)
	);

	// one multiplier-free cell per folded pair
	for (genvar k = 0; k < num_pairs; k++) begin : g_tap
		tx_mf_tap i_tap (
			.pair_sum (pair_sum[k]),
			.coef     (tap_coef[k]),
			.product  (product[k])
		);
	end

	tx_mf_adder_tree i_adder_tree (
		.clk      (clk),
		.reset    (reset),
		.product  (product),
		.filt_out (filt_out)
	);

endmodule

/* tb/tx_mf_tb_model.svh */
`ifndef TX_MF_TB_MODEL_SVH
`define TX_MF_TB_MODEL_SVH

// generator state, seeded once
int unsigned lcg_state = 32'd29012;

// reference copy of the delay line, index 0 is the newest sample
int model_hist [num_taps];

function automatic int unsigned lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	// low bits of an LCG repeat quickly, use the upper ones
	return lcg_state >> 8;
endfunction

// symbol codes 0..3 sit at -3, -1, +1, +3 level units
function automatic int level_of(input int code);
	return (2 * code - 3) * level_unit;
endfunction

function automatic void model_clear();
	for (int i = 0; i < num_taps; i++) begin
		model_hist[i] = 0;
	end
endfunction

function automatic void model_push(input int sample);
	for (int i = num_taps - 1; i > 0; i--) begin
		model_hist[i] = model_hist[i-1];
	end
	model_hist[0] = sample;
endfunction

// a pair sum strictly inside the window of level m gives m x coef
function automatic int pair_product(input int ps, input int coef);
	int result;
	int level;
	result = 0;
	for (int m = -3; m <= 3; m++) begin
		level = 2 * m * level_unit;
		if ((ps > level - level_tol) && (ps < level + level_tol)) begin
			result = m * coef;
		end
	end
	return result;
endfunction

function automatic int model_output();
	int acc;
	int ps;
	acc = 0;
	for (int k = 0; k < num_pairs - 1; k++) begin
		ps = model_hist[k] + model_hist[num_taps-1-k];
		acc += pair_product(ps, int'(tap_coef[k]));
	end
	// center sample pairs with itself
	ps = 2 * model_hist[num_pairs-1];
	acc += pair_product(ps, int'(tap_coef[num_pairs-1]));
	return acc;
endfunction

`endif

/* tb/tx_mf_tb.sv */
`timescale 1ns/1ps

module tx_mf_tb;
	import tx_mf_pkg::*;

	localparam int clk_period_ns = 40;
	localparam int random_count = 200;
	localparam int mixed_count = 100;
	localparam int edge_cases = 8;
	// reset read, unused write and read, impulse fill plus 21 write/read pairs,
	// then one unused write and read over the impulse history
	localparam int planned_accesses = 1 + 2 + 3 * num_taps + 2 + 2 * random_count
		+ edge_cases * (num_taps + 1) + 2 * mixed_count;
	localparam int cycles_per_access = 200;

	// first sample of a tolerance case, and the offsets of its partner
	localparam int edge_bases [2] = '{-3 * level_unit, level_unit};
	localparam int edge_offsets [4] = '{
		level_tol - 1,
		-(level_tol - 1),
		level_tol,
		-level_tol
	};

	logic clk;
	logic reset;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [1:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic wb_ack;

	`include "tx_mf_tb_model.svh"

	tx_mf_top i_dut (
		.clk      (clk),
		.reset    (reset),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period_ns / 2) clk = ~clk;
	end

	initial begin
		#(planned_accesses * cycles_per_access * clk_period_ns);
		$display("Timeout: the bus accesses did not complete in time");
		stop_run();
	end

	task automatic stop_run();
		$display("Something failed");
		$fatal(1, "run stopped");
	endtask

	task automatic report_mismatch(input string what, input int expected, input int actual);
		$display("** Error at %0t: %s, expected %0d, got %0d", $time, what, expected, actual);
		stop_run();
	endtask

	task automatic report_problem(input string what);
		$display("Problem at %0t: %s", $time, what);
		stop_run();
	endtask

	// one classic cycle, signals held until the ack is seen
	task automatic bus_access(input logic we, input logic [1:0] adr, input logic [31:0] data,
		output logic [31:0] rdata);
		int wait_cycles;
		@(negedge clk);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = data;
		@(negedge clk);
		wait_cycles = 1;
		while (!wb_ack) begin
			@(negedge clk);
			wait_cycles++;
		end
		rdata = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		assert (wait_cycles == 1) else report_mismatch("ack latency in cycles", 1, wait_cycles);
		@(negedge clk);
		assert (!wb_ack) else report_problem("wb_ack stayed high for a second cycle");
	endtask

	task automatic wb_write(input logic [1:0] adr, input logic [31:0] data);
		logic [31:0] ignored;
		bus_access(1'b1, adr, data, ignored);
	endtask

	task automatic wb_read(input logic [1:0] adr, output logic [31:0] data);
		bus_access(1'b0, adr, 32'd0, data);
	endtask

	task automatic push_symbol(input int code);
		wb_write(reg_symbol, 32'(code));
		model_push(level_of(code));
	endtask

	task automatic push_raw(input int value);
		wb_write(reg_sample, 32'(value));
		model_push(value);
	endtask

	task automatic check_against_model(input string what);
		logic [31:0] data;
		int expected;
		expected = model_output();
		wb_read(reg_output, data);
		assert ($signed(data) == expected) else report_mismatch(what, expected, $signed(data));
	endtask

	initial begin
		logic [31:0] data;
		int base;
		int expected;
		int code;
		int offset;
		reset = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = 2'd0;
		wb_dat_w = 32'd0;
		model_clear();
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		assert (!wb_ack) else report_problem("wb_ack high right after reset");
		wb_read(reg_output, data);
		assert (data == 32'd0) else report_mismatch("output after reset", 0, $signed(data));

		// unused address is acked and reads as zero
		wb_write(reg_unused, 32'hffff_ffff);
		wb_read(reg_unused, data);
		assert (data == 32'd0) else report_mismatch("unused register read", 0, $signed(data));

		// impulse over a +1 background, every pair starts on level 1
		base = 0;
		for (int k = 0; k < num_pairs; k++) begin
			base += int'(tap_coef[k]);
		end
		for (int i = 0; i < num_taps; i++) begin
			push_symbol(2);
		end
		for (int pos = 0; pos < num_taps; pos++) begin
			push_symbol((pos == 0) ? 3 : 2);
			// the +3 sample lifts its pair one level, the doubled center two
			if (pos == num_pairs - 1) begin
				expected = base + 2 * int'(tap_coef[num_pairs-1]);
			end else if (pos < num_pairs - 1) begin
				expected = base + int'(tap_coef[pos]);
			end else begin
				expected = base + int'(tap_coef[num_taps-1-pos]);
			end
			wb_read(reg_output, data);
			assert ($signed(data) == expected)
				else report_mismatch("impulse response", expected, $signed(data));
		end

		// the +3 sample sits at the far end, any stray shift would change the output
		wb_write(reg_unused, 32'd0);
		check_against_model("output after unused write");

		for (int i = 0; i < random_count; i++) begin
			code = int'(lcg_next() % 4);
			push_symbol(code);
			check_against_model("random symbol output");
		end

		// pair 0 built from two samples 20 pushes apart
		for (int b = 0; b < 2; b++) begin
			for (int e = 0; e < 4; e++) begin
				push_raw(edge_bases[b]);
				repeat (num_taps - 2) push_raw(0);
				push_raw(edge_bases[b] + edge_offsets[e]);
				check_against_model("tolerance edge output");
			end
		end

		for (int i = 0; i < mixed_count; i++) begin
			if (lcg_next() % 3 == 0) begin
				code = int'(lcg_next() % 4);
				offset = int'(lcg_next() % 12001) - 6000;
				push_raw(level_of(code) + offset);
			end else begin
				push_symbol(int'(lcg_next() % 4));
			end
			check_against_model("mixed off-level output");
		end

		$display("Everything OK");
		$finish;
	end

endmodule

/* compile.f */
+incdir+tb
logic/tx_mf_pkg.sv
logic/tx_mf_tap.sv
logic/tx_mf_delay_line.sv
logic/tx_mf_adder_tree.sv
logic/tx_mf_wb_regs.sv
logic/tx_mf_top.sv
tb/tx_mf_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the tx_mf testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps \
	--top-module tx_mf_tb -Mdir obj_dir -f compile.f > "$BUILD_LOG" 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "build failed with status $build_status"
	exit 1
fi

./obj_dir/Vtx_mf_tb > "$SIM_LOG" 2>&1
run_status=$?
cat "$SIM_LOG"

if grep -q "Something failed" "$SIM_LOG"; then
	echo "simulation FAILED"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

echo "simulation passed"
exit 0
